// ==== verilog/llc_pkg.sv ====
package llc_pkg;

    // the byte address holds the tag above the set above the line offset
    localparam int addr_bits    = 32;
    localparam int offset_bits  = 4;
    localparam int llc_set_bits = 8;
    localparam int llc_tag_bits = addr_bits - offset_bits - llc_set_bits;

    // a line address drops the offset within the line
    localparam int line_addr_bits = addr_bits - offset_bits;

    // bytes covered by one line, the step of a DMA walk
    localparam int line_bytes = 1 << offset_bits;

    // full byte address as seen by the DMA engine
    typedef logic [addr_bits-1:0] addr_t;

    // set index sits in the low bits, tag in the upper bits
    typedef logic [line_addr_bits-1:0] line_addr_t;

    typedef logic [llc_set_bits-1:0] llc_set_t;

    typedef logic [llc_tag_bits-1:0] llc_tag_t;

endpackage

// ==== verilog/llc_input_select.sv ====
`timescale 1ns/1ps

module llc_input_select (
    input  logic rst_stall,
    input  logic flush_stall,
    input  logic rsp_valid,
    input  logic req_valid,
    input  logic req_stall,
    input  logic dma_req_valid,
    input  logic dma_resume,
    input  logic dma_active,
    output logic is_rst_to_resume,
    output logic is_flush_to_resume,
    output logic is_rsp_to_get,
    output logic is_req_to_get,
    output logic is_dma_req_to_get,
    output logic is_dma_resume,
    output logic rd_set_en,
    output logic rsp_ack,
    output logic req_ack,
    output logic dma_ack
);

    logic req_ok;    // request allowed to compete
    logic resume_ok; // resume has a live transfer behind it

    assign req_ok    = req_valid & ~req_stall;
    assign resume_ok = dma_resume & dma_active;

    // strict priority lets only one strobe go high in a cycle
    always_comb begin
        is_rst_to_resume   = 1'b0;
        is_flush_to_resume = 1'b0;
        is_rsp_to_get      = 1'b0;
        is_req_to_get      = 1'b0;
        is_dma_req_to_get  = 1'b0;
        is_dma_resume      = 1'b0;

        if (rst_stall) begin
            is_rst_to_resume = 1'b1;
        end else if (flush_stall) begin
            is_flush_to_resume = 1'b1;
        end else if (rsp_valid) begin
            is_rsp_to_get = 1'b1; // responses drain ahead of new work
        end else if (req_ok) begin
            is_req_to_get = 1'b1;
        end else if (dma_req_valid) begin
            is_dma_req_to_get = 1'b1;
        end else if (resume_ok) begin
            is_dma_resume = 1'b1;
        end
    end

    assign rd_set_en = is_rst_to_resume | is_flush_to_resume | is_rsp_to_get |
                       is_req_to_get | is_dma_req_to_get | is_dma_resume;

    // a source drops its valid once it sees its ack
    assign rsp_ack = is_rsp_to_get;
    assign req_ack = is_req_to_get;
    assign dma_ack = is_dma_req_to_get | is_dma_resume; // new transfer or next line

endmodule

// ==== verilog/llc_read_set.sv ====
`timescale 1ns/1ps

module llc_read_set import llc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rd_set_en,
    input  line_addr_t rsp_in_addr,
    input  line_addr_t req_in_addr,
    input  line_addr_t dma_req_in_addr,
    input  addr_t      dma_addr,
    input  llc_set_t   sweep_set,
    input  llc_set_t   req_in_stalled_set,
    input  llc_tag_t   req_in_stalled_tag,
    input  logic       req_stall,
    input  logic       is_rst_to_resume,
    input  logic       is_flush_to_resume,
    input  logic       is_rsp_to_get,
    input  logic       is_req_to_get,
    input  logic       is_dma_req_to_get,
    input  logic       is_dma_resume,
    output llc_set_t   set,
    output llc_set_t   line_set,
    output llc_tag_t   line_tag,
    output logic       incr_sweep_set,
    output logic       clr_rst_stall,
    output logic       clr_flush_stall,
    output logic       clr_req_stall,
    output logic       update_dma_addr_from_req
);

    line_addr_t addr_for_set;
    llc_set_t   set_next;
    llc_tag_t   tag_next;
    logic       sweep;
    logic       sweep_last;

    assign sweep      = is_rst_to_resume | is_flush_to_resume;
    assign sweep_last = (sweep_set == '1);

    always_comb begin
        addr_for_set             = '0;
        update_dma_addr_from_req = 1'b0;
        if (is_rsp_to_get) begin
            addr_for_set = rsp_in_addr;
        end else if (is_req_to_get) begin
            addr_for_set = req_in_addr;
        end else if (is_dma_req_to_get || is_dma_resume) begin
            // a resume looks up the line the running address points at
            addr_for_set = is_dma_req_to_get ? dma_req_in_addr
                                             : dma_addr[addr_bits-1:offset_bits];
            update_dma_addr_from_req = 1'b1;
        end
    end

    assign set_next = addr_for_set[llc_set_bits-1:0];
    assign tag_next = addr_for_set[line_addr_bits-1:llc_set_bits];

    // the sweep counter steps every sweep cycle and the last set ends the sweep
    assign incr_sweep_set  = sweep;
    assign clr_rst_stall   = is_rst_to_resume & sweep_last;
    assign clr_flush_stall = is_flush_to_resume & sweep_last;

    // a response for the parked line lets the request go again
    assign clr_req_stall = is_rsp_to_get & req_stall &
                           (tag_next == req_in_stalled_tag) &
                           (set_next == req_in_stalled_set);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            line_set <= '0;
            line_tag <= '0;
        end else if (rd_set_en) begin
            line_set <= set_next;
            line_tag <= tag_next;
        end
    end

    assign set = sweep ? sweep_set : line_set; // sweep index goes straight out

endmodule

// ==== verilog/llc_stall_ctrl.sv ====
`timescale 1ns/1ps

module llc_stall_ctrl import llc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       flush_start,
    input  logic       req_park,
    input  logic       incr_sweep_set,
    input  logic       clr_rst_stall,
    input  logic       clr_flush_stall,
    input  logic       clr_req_stall,
    input  logic       update_dma_addr_from_req,
    input  logic       is_dma_req_to_get,
    input  logic       dma_resume,
    input  line_addr_t dma_req_addr,
    input  llc_set_t   line_set,
    input  llc_tag_t   line_tag,
    output logic       rst_stall,
    output logic       flush_stall,
    output logic       req_stall,
    output logic       dma_active,
    output llc_set_t   sweep_set,
    output llc_set_t   stalled_set,
    output llc_tag_t   stalled_tag,
    output addr_t      dma_addr
);

    logic sweep_running;

    assign sweep_running = rst_stall | flush_stall;

    // the reset sweep runs once straight out of reset
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall <= 1'b1;
        end else if (clr_rst_stall) begin
            rst_stall <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_stall <= 1'b0;
        end else if (clr_flush_stall) begin
            flush_stall <= 1'b0;
        end else if (flush_start && !sweep_running) begin
            flush_stall <= 1'b1; // a flush pulse mid sweep is dropped
        end
    end

    // the 8-bit counter wraps back to 0 after set 255
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            sweep_set <= '0;
        end else if (incr_sweep_set) begin
            sweep_set <= sweep_set + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_stall <= 1'b0;
        end else if (req_park) begin
            req_stall <= 1'b1;
        end else if (clr_req_stall) begin
            req_stall <= 1'b0;
        end
    end

    // parked line is what sits on the lookup outputs at the park pulse
    always_ff @(posedge clk) begin
        if (req_park) begin
            stalled_set <= line_set;
            stalled_tag <= line_tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dma_addr <= '0;
        end else if (update_dma_addr_from_req) begin
            if (is_dma_req_to_get) begin
                dma_addr <= {dma_req_addr, {offset_bits{1'b0}}};
            end else begin
                dma_addr <= dma_addr + addr_t'(line_bytes); // next line
            end
        end
    end

    // transfer ends as soon as resume drops with no new request behind it
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            dma_active <= 1'b0;
        end else if (is_dma_req_to_get) begin
            dma_active <= 1'b1;
        end else if (!dma_resume) begin
            dma_active <= 1'b0;
        end
    end

endmodule

// ==== verilog/llc_front.sv ====
`timescale 1ns/1ps

module llc_front import llc_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rsp_valid,
    input  logic       req_valid,
    input  logic       dma_req_valid,
    input  logic       dma_resume,
    input  logic       flush_start,
    input  logic       req_park,
    input  line_addr_t rsp_addr,
    input  line_addr_t req_addr,
    input  line_addr_t dma_req_addr,
    output logic       lookup_valid,
    output logic       rsp_ack,
    output logic       req_ack,
    output logic       dma_ack,
    output logic       sweep_busy,
    output logic       req_stall,
    output llc_set_t   lookup_set,
    output llc_tag_t   lookup_tag,
    output addr_t      dma_addr
);

    logic     rst_stall;
    logic     flush_stall;
    logic     dma_active;
    logic     is_rst_to_resume;
    logic     is_flush_to_resume;
    logic     is_rsp_to_get;
    logic     is_req_to_get;
    logic     is_dma_req_to_get;
    logic     is_dma_resume;
    logic     rd_set_en;
    logic     incr_sweep_set;
    logic     clr_rst_stall;
    logic     clr_flush_stall;
    logic     clr_req_stall;
    logic     update_dma_addr_from_req;
    llc_set_t sweep_set;
    llc_set_t stalled_set;
    llc_tag_t stalled_tag;
    llc_set_t line_set;

    llc_input_select i_input_select (
        .rst_stall          (rst_stall),
        .flush_stall        (flush_stall),
        .rsp_valid          (rsp_valid),
        .req_valid          (req_valid),
        .req_stall          (req_stall),
        .dma_req_valid      (dma_req_valid),
        .dma_resume         (dma_resume),
        .dma_active         (dma_active),
        .is_rst_to_resume   (is_rst_to_resume),
        .is_flush_to_resume (is_flush_to_resume),
        .is_rsp_to_get      (is_rsp_to_get),
        .is_req_to_get      (is_req_to_get),
        .is_dma_req_to_get  (is_dma_req_to_get),
        .is_dma_resume      (is_dma_resume),
        .rd_set_en          (rd_set_en),
        .rsp_ack            (rsp_ack),
        .req_ack            (req_ack),
        .dma_ack            (dma_ack)
    );

    llc_read_set i_read_set (
        .clk                      (clk),
        .rst                      (rst),
        .rd_set_en                (rd_set_en),
        .rsp_in_addr              (rsp_addr),
        .req_in_addr              (req_addr),
        .dma_req_in_addr          (dma_req_addr),
        .dma_addr                 (dma_addr),
        .sweep_set                (sweep_set),
        .req_in_stalled_set       (stalled_set),
        .req_in_stalled_tag       (stalled_tag),
        .req_stall                (req_stall),
        .is_rst_to_resume         (is_rst_to_resume),
        .is_flush_to_resume       (is_flush_to_resume),
        .is_rsp_to_get            (is_rsp_to_get),
        .is_req_to_get            (is_req_to_get),
        .is_dma_req_to_get        (is_dma_req_to_get),
        .is_dma_resume            (is_dma_resume),
        .set                      (lookup_set),
        .line_set                 (line_set),
        .line_tag                 (lookup_tag),
        .incr_sweep_set           (incr_sweep_set),
        .clr_rst_stall            (clr_rst_stall),
        .clr_flush_stall          (clr_flush_stall),
        .clr_req_stall            (clr_req_stall),
        .update_dma_addr_from_req (update_dma_addr_from_req)
    );

    llc_stall_ctrl i_stall_ctrl (
        .clk                      (clk),
        .rst                      (rst),
        .flush_start              (flush_start),
        .req_park                 (req_park),
        .incr_sweep_set           (incr_sweep_set),
        .clr_rst_stall            (clr_rst_stall),
        .clr_flush_stall          (clr_flush_stall),
        .clr_req_stall            (clr_req_stall),
        .update_dma_addr_from_req (update_dma_addr_from_req),
        .is_dma_req_to_get        (is_dma_req_to_get),
        .dma_resume               (dma_resume),
        .dma_req_addr             (dma_req_addr),
        .line_set                 (line_set),
        .line_tag                 (lookup_tag),
        .rst_stall                (rst_stall),
        .flush_stall              (flush_stall),
        .req_stall                (req_stall),
        .dma_active               (dma_active),
        .sweep_set                (sweep_set),
        .stalled_set              (stalled_set),
        .stalled_tag              (stalled_tag),
        .dma_addr                 (dma_addr)
    );

    assign sweep_busy = rst_stall | flush_stall;

    // sweep cycles read a set but never present a lookup
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= rd_set_en & ~(is_rst_to_resume | is_flush_to_resume);
        end
    end

endmodule

// ==== test/llc_front_checker.sv ====
`timescale 1ns/1ps

module llc_front_checker (
    input logic clk,
    input logic rst,
    input logic lookup_valid,
    input logic rsp_ack,
    input logic req_ack,
    input logic dma_ack,
    input logic sweep_busy
);

    int assert_fails = 0;

    // the front end picks one source per cycle
    single_ack: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({rsp_ack, req_ack, dma_ack}))
        else begin
            assert_fails++;
            $error("more than one acknowledge in one cycle");
        end

    no_lookup_in_sweep: assert property (@(posedge clk) disable iff (!rst)
        sweep_busy |-> !lookup_valid)
        else begin
            assert_fails++;
            $error("lookup_valid high while a sweep is running");
        end

    ack_then_lookup: assert property (@(posedge clk) disable iff (!rst)
        (rsp_ack | req_ack | dma_ack) |=> lookup_valid) // lookup lands one cycle on
        else begin
            assert_fails++;
            $error("acknowledge not followed by lookup_valid");
        end

endmodule

bind llc_front llc_front_checker i_checker (
    .clk          (clk),
    .rst          (rst),
    .lookup_valid (lookup_valid),
    .rsp_ack      (rsp_ack),
    .req_ack      (req_ack),
    .dma_ack      (dma_ack),
    .sweep_busy   (sweep_busy)
);

// ==== test/llc_front_tb.sv ====
`timescale 1ns/1ps

module llc_front_tb import llc_pkg::*; ();

    localparam int clk_period = 20;
    localparam int sweep_len  = 1 << llc_set_bits;
    localparam int src_none   = 0;
    localparam int src_rst    = 1;
    localparam int src_flush  = 2;
    localparam int src_rsp    = 3;
    localparam int src_req    = 4;
    localparam int src_dma    = 5;
    localparam int src_resume = 6;

    // each row fires its events on its first cycle and holds the resume level for all its cycles
    typedef struct packed {
        logic        rsp_new;
        logic        req_new;
        logic        dma_new;
        line_addr_t  rsp_a;
        line_addr_t  req_a;
        line_addr_t  dma_a;
        logic        flush;
        logic        park;
        logic        resume;
        logic [15:0] cycles;
        logic [7:0]  exp_acks;
    } step_t;

    logic       clk = 1'b0;
    logic       rst;
    logic       rsp_valid;
    logic       req_valid;
    logic       dma_req_valid;
    logic       dma_resume;
    logic       flush_start;
    logic       req_park;
    line_addr_t rsp_addr;
    line_addr_t req_addr;
    line_addr_t dma_req_addr;
    logic       lookup_valid;
    logic       rsp_ack;
    logic       req_ack;
    logic       dma_ack;
    logic       sweep_busy;
    logic       req_stall;
    llc_set_t   lookup_set;
    llc_tag_t   lookup_tag;
    addr_t      dma_addr;

    step_t steps[$];
    int    total_cycles = 0;
    int    ack_count;
    logic  table_ready = 1'b0;
    logic  rsp_taken;
    logic  req_taken;
    logic  dma_taken;

    // reference model state
    logic       ref_rst_stall;
    logic       ref_flush_stall;
    llc_set_t   ref_sweep_set;
    logic       ref_req_stall;
    line_addr_t ref_stalled;
    logic       ref_dma_active;
    addr_t      ref_dma_addr;
    line_addr_t ref_line;
    logic       ref_lookup_valid;

    llc_front i_llc_front (.*);

    always #(clk_period / 2) clk = ~clk;

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic step_t blank_step(input int cycles, input int exp_acks);
        step_t s;
        s          = '0;
        s.rsp_a    = line_addr_t'($urandom);
        s.req_a    = line_addr_t'($urandom);
        s.dma_a    = line_addr_t'($urandom);
        s.cycles   = cycles[15:0];
        s.exp_acks = exp_acks[7:0];
        return s;
    endfunction

    task automatic add_step(input step_t s);
        steps.push_back(s);
        total_cycles += int'(s.cycles);
    endtask

    task automatic build_table();
        step_t      s;
        line_addr_t parked;
        s = blank_step(sweep_len + 2, 1); // request waits out the reset sweep
        s.req_new = 1'b1;
        s.flush   = 1'b1;                 // dropped since the reset sweep is running
        add_step(s);
        s = blank_step(5, 3);
        s.rsp_new = 1'b1;
        s.req_new = 1'b1;
        s.dma_new = 1'b1;
        add_step(s);
        s = blank_step(1, 1);
        s.req_new = 1'b1;
        parked    = s.req_a;
        add_step(s);
        s = blank_step(1, 0);
        s.park = 1'b1;
        add_step(s);
        s = blank_step(3, 0);
        s.req_new = 1'b1;
        add_step(s);
        s = blank_step(2, 1);
        s.rsp_new = 1'b1;
        s.rsp_a   = parked ^ line_addr_t'(1 << llc_set_bits); // same set with another tag
        add_step(s);
        s = blank_step(3, 2);
        s.rsp_new = 1'b1;
        s.rsp_a   = parked;
        add_step(s);
        s = blank_step(1, 1);
        s.dma_new = 1'b1;
        add_step(s);
        s = blank_step(4, 4);
        s.resume = 1'b1;
        add_step(s);
        add_step(blank_step(2, 0));
        s = blank_step(2, 0);
        s.resume = 1'b1; // no transfer is active any more
        add_step(s);
        s = blank_step(2, 0);
        s.flush = 1'b1;
        add_step(s);
        s = blank_step(sweep_len + 4, 3);
        s.rsp_new = 1'b1;
        s.req_new = 1'b1;
        s.dma_new = 1'b1;
        add_step(s);
        add_step(blank_step(3, 0));
    endtask

    task automatic reset_model();
        ref_rst_stall    = 1'b1;
        ref_flush_stall  = 1'b0;
        ref_sweep_set    = '0;
        ref_req_stall    = 1'b0;
        ref_stalled      = '0;
        ref_dma_active   = 1'b0;
        ref_dma_addr     = '0;
        ref_line         = '0;
        ref_lookup_valid = 1'b0;
    endtask

    function automatic int pick_source();
        if (ref_rst_stall)
            return src_rst;
        if (ref_flush_stall)
            return src_flush;
        if (rsp_valid)
            return src_rsp;
        if (req_valid && !ref_req_stall)
            return src_req;
        if (dma_req_valid)
            return src_dma;
        if (dma_resume && ref_dma_active)
            return src_resume;
        return src_none;
    endfunction

    task automatic update_model(input int sel);
        logic flush_begin;
        logic release_stall;
        logic sweep_last;
        flush_begin   = flush_start && !ref_rst_stall && !ref_flush_stall;
        release_stall = (sel == src_rsp) && ref_req_stall && (rsp_addr == ref_stalled);
        sweep_last    = (ref_sweep_set == llc_set_t'(sweep_len - 1));
        if (req_park) begin
            ref_stalled   = ref_line;
            ref_req_stall = 1'b1;
        end else if (release_stall) begin
            ref_req_stall = 1'b0;
        end
        ref_lookup_valid = (sel >= src_rsp);
        case (sel)
            src_rst, src_flush: begin
                ref_line      = '0;
                ref_sweep_set = ref_sweep_set + 1'b1;
                if (sweep_last && sel == src_rst)
                    ref_rst_stall = 1'b0;
                if (sweep_last && sel == src_flush)
                    ref_flush_stall = 1'b0;
            end
            src_rsp: ref_line = rsp_addr;
            src_req: ref_line = req_addr;
            src_dma: begin
                ref_line     = dma_req_addr;
                ref_dma_addr = {dma_req_addr, 4'b0000};
            end
            src_resume: begin
                ref_line     = ref_dma_addr[addr_bits-1:offset_bits];
                ref_dma_addr = ref_dma_addr + addr_t'(16);
            end
            default: begin
            end
        endcase
        if (flush_begin)
            ref_flush_stall = 1'b1;
        if (sel == src_dma)
            ref_dma_active = 1'b1;
        else if (!dma_resume)
            ref_dma_active = 1'b0;
    endtask

    task automatic verify_outputs();
        int       sel;
        llc_set_t exp_set;
        sel = pick_source();
        if (i_llc_front.i_checker.assert_fails != 0) begin
            $display("an assertion in llc_front_checker failed before %0t", $time);
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end
        exp_set = (sel == src_rst || sel == src_flush) ? ref_sweep_set
                                                       : ref_line[llc_set_bits-1:0];
        compare("rsp_ack", rsp_ack, sel == src_rsp);
        compare("req_ack", req_ack, sel == src_req);
        compare("dma_ack", dma_ack, sel == src_dma || sel == src_resume);
        compare("lookup_valid", lookup_valid, ref_lookup_valid);
        compare("lookup_set", lookup_set, exp_set);
        compare("lookup_tag", lookup_tag, ref_line[line_addr_bits-1:llc_set_bits]);
        compare("sweep_busy", sweep_busy, ref_rst_stall | ref_flush_stall);
        compare("req_stall", req_stall, ref_req_stall);
        compare("dma_addr", dma_addr, ref_dma_addr);
        ack_count = ack_count + int'(rsp_ack) + int'(req_ack) + int'(dma_ack);
        rsp_taken = rsp_ack; // each source drops its valid after its ack
        req_taken = req_ack;
        dma_taken = dma_ack;
        update_model(sel);
    endtask

    task automatic drive_inputs(input step_t s, input logic first);
        if (rsp_taken)
            rsp_valid = 1'b0;
        if (req_taken)
            req_valid = 1'b0;
        if (dma_taken)
            dma_req_valid = 1'b0;
        flush_start = first & s.flush;
        req_park    = first & s.park;
        dma_resume  = s.resume;
        if (first && s.rsp_new) begin
            rsp_valid = 1'b1;
            rsp_addr  = s.rsp_a;
        end
        if (first && s.req_new) begin
            req_valid = 1'b1;
            req_addr  = s.req_a;
        end
        if (first && s.dma_new) begin
            dma_req_valid = 1'b1;
            dma_req_addr  = s.dma_a;
        end
    endtask

    initial begin
        void'($urandom(56903));
        rst           = 1'b0;
        rsp_valid     = 1'b0;
        req_valid     = 1'b0;
        dma_req_valid = 1'b0;
        dma_resume    = 1'b0;
        flush_start   = 1'b0;
        req_park      = 1'b0;
        rsp_addr      = '0;
        req_addr      = '0;
        dma_req_addr  = '0;
        rsp_taken     = 1'b0;
        req_taken     = 1'b0;
        dma_taken     = 1'b0;
        build_table();
        reset_model();
        table_ready = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b1;
        foreach (steps[i]) begin
            ack_count = 0;
            for (int c = 0; c < int'(steps[i].cycles); c++) begin
                drive_inputs(steps[i], c == 0);
                @(negedge clk);
                verify_outputs();
                @(posedge clk);
                #2;
            end
            compare("ack_count", ack_count, steps[i].exp_acks);
        end
        rsp_valid     = 1'b0;
        req_valid     = 1'b0;
        dma_req_valid = 1'b0;
        dma_resume    = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        if (i_llc_front.i_checker.assert_fails == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("llc_front_checker saw %0d failed assertions",
                     i_llc_front.i_checker.assert_fails);
            $display("TEST FAILED");
            $fatal(1, "assertion failures");
        end
    end

    // limit covers the table, two full sweeps and the reset time
    initial begin
        int limit_ns;
        wait (table_ready);
        limit_ns = (total_cycles + 2 * sweep_len + 16 + 50) * clk_period;
        #(limit_ns);
        $display("Timeout: the run did not finish within %0d ns", limit_ns);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== llc_front.f ====
verilog/llc_pkg.sv
verilog/llc_input_select.sv
verilog/llc_read_set.sv
verilog/llc_stall_ctrl.sv
verilog/llc_front.sv
test/llc_front_checker.sv
test/llc_front_tb.sv

// ==== Bender.yml ====
package:
  name: llc_front

sources:
  - files:
      - verilog/llc_pkg.sv
      - verilog/llc_input_select.sv
      - verilog/llc_read_set.sv
      - verilog/llc_stall_ctrl.sv
      - verilog/llc_front.sv
  - target: test
    files:
      - test/llc_front_checker.sv
      - test/llc_front_tb.sv
